//--- verilog/issue_pkg.sv
package issue_pkg;

	localparam int XLEN      = 32;
	localparam int NUM_PREGS = 64;
	localparam int PREG_W    = 6;
	localparam int RS_DEPTH  = 16;
	localparam int RS_IDX_W  = 4;
	localparam int ROB_W     = 4;
	localparam int NUM_FU    = 2;
	localparam int FU_W      = 1;

	// Major opcodes kept by this stage
	typedef enum logic [6:0] {
		OPC_OP_IMM = 7'b0010011, // ADDI, ANDI
		OPC_OP     = 7'b0110011  // ADD, SUB, XOR, SRA
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_SRA,
		ALU_AND
	} alu_op_e;

	// Renamed instruction from the rename stage
	typedef struct packed {
		logic [31:0]       instr;
		logic [PREG_W-1:0] ps1;
		logic [PREG_W-1:0] ps2;
		logic [PREG_W-1:0] pd;
		logic [ROB_W-1:0]  rob;
	} disp_req_t;

	typedef struct packed {
		logic              in_use;
		alu_op_e           op;
		logic [PREG_W-1:0] pd;
		logic [ROB_W-1:0]  rob;
		logic [FU_W-1:0]   fu;
		logic [PREG_W-1:0] src1_tag;
		logic [PREG_W-1:0] src2_tag;
		logic [XLEN-1:0]   src1_val;
		logic [XLEN-1:0]   src2_val;
		logic              src1_rdy;
		logic              src2_rdy;
	} rs_entry_t;

	typedef struct packed {
		alu_op_e           op;
		logic [XLEN-1:0]   opa;
		logic [XLEN-1:0]   opb;
		logic [PREG_W-1:0] pd;
		logic [ROB_W-1:0]  rob;
	} issue_t;

	typedef struct packed {
		logic              valid;
		logic [PREG_W-1:0] pd;
		logic [XLEN-1:0]   data;
		logic [ROB_W-1:0]  rob;
		logic [FU_W-1:0]   fu;
	} cdb_t;

	// One register file read port result
	typedef struct packed {
		logic            ready;
		logic [XLEN-1:0] value;
	} src_t;

endpackage

//--- verilog/dispatch_decode.sv
`timescale 1ns/100ps

module dispatch_decode (
	input  logic                         clk,
	input  logic                         i_arst_n,
	input  logic                         i_accept,
	input  issue_pkg::disp_req_t         i_disp,
	output logic [issue_pkg::PREG_W-1:0] o_ps1,
	output logic [issue_pkg::PREG_W-1:0] o_ps2,
	input  issue_pkg::src_t              i_src1,
	input  issue_pkg::src_t              i_src2,
	output issue_pkg::rs_entry_t         o_entry
);

	logic              alt_q; // Unit for the next accepted instruction
	logic [2:0]        funct3;
	logic              funct7_b5;
	issue_pkg::opcode_e opcode;

	assign o_ps1     = i_disp.ps1;
	assign o_ps2     = i_disp.ps2;
	assign opcode    = issue_pkg::opcode_e'(i_disp.instr[6:0]);
	assign funct3    = i_disp.instr[14:12];
	assign funct7_b5 = i_disp.instr[30]; // Picks SUB and SRA

	always_comb begin
		o_entry          = '0;
		o_entry.in_use   = 1'b1;
		o_entry.pd       = i_disp.pd;
		o_entry.rob      = i_disp.rob;
		o_entry.fu       = alt_q;
		o_entry.src1_tag = i_disp.ps1;
		o_entry.src1_val = i_src1.value;
		o_entry.src1_rdy = i_src1.ready;
		o_entry.op       = issue_pkg::ALU_ADD;

		if (opcode == issue_pkg::OPC_OP) begin
			o_entry.src2_tag = i_disp.ps2;
			o_entry.src2_val = i_src2.value;
			o_entry.src2_rdy = i_src2.ready;
			case (funct3)
				3'b000:  o_entry.op = funct7_b5 ? issue_pkg::ALU_SUB : issue_pkg::ALU_ADD;
				3'b100:  o_entry.op = issue_pkg::ALU_XOR;
				3'b101:  o_entry.op = issue_pkg::ALU_SRA;
				default: o_entry.op = issue_pkg::ALU_ADD;
			endcase
		end else begin
			// Immediate is zero-extended, always ready
			o_entry.src2_tag = '0;
			o_entry.src2_val = {20'b0, i_disp.instr[31:20]};
			o_entry.src2_rdy = 1'b1;
			o_entry.op       = (funct3 == 3'b111) ? issue_pkg::ALU_AND : issue_pkg::ALU_ADD;
		end

		// x0 reads as zero and never waits
		if (i_disp.ps1 == '0) begin
			o_entry.src1_val = '0;
			o_entry.src1_rdy = 1'b1;
		end
		if (opcode == issue_pkg::OPC_OP && i_disp.ps2 == '0) begin
			o_entry.src2_val = '0;
			o_entry.src2_rdy = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			alt_q <= 1'b0;
		else if (i_accept)
			alt_q <= ~alt_q;
	end

endmodule

//--- verilog/phys_regfile.sv
`timescale 1ns/100ps

module phys_regfile (
	input  logic                         clk,
	input  logic                         i_arst_n,
	input  logic [issue_pkg::PREG_W-1:0] i_ps1,
	input  logic [issue_pkg::PREG_W-1:0] i_ps2,
	output issue_pkg::src_t              o_src1,
	output issue_pkg::src_t              o_src2,
	input  logic                         i_alloc_valid,
	input  logic [issue_pkg::PREG_W-1:0] i_alloc_pd,
	input  issue_pkg::cdb_t              i_cdb
);

	logic [issue_pkg::XLEN-1:0]      regs_q [issue_pkg::NUM_PREGS];
	logic [issue_pkg::NUM_PREGS-1:0] rdy_q;
	logic                            cdb_wr; // Broadcast that lands in the file

	assign cdb_wr = i_cdb.valid && (i_cdb.pd != '0);

	// Read with same-cycle bypass from the CDB
	function automatic issue_pkg::src_t read_port(input logic [issue_pkg::PREG_W-1:0] ps);
		issue_pkg::src_t rd;
		if (cdb_wr && i_cdb.pd == ps) begin
			rd.ready = 1'b1;
			rd.value = i_cdb.data;
		end else begin
			rd.ready = rdy_q[ps];
			rd.value = regs_q[ps];
		end
		return rd;
	endfunction

	always_comb begin
		o_src1 = read_port(i_ps1);
		o_src2 = read_port(i_ps2);
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rdy_q <= '1;
			for (int i = 0; i < issue_pkg::NUM_PREGS; i++)
				regs_q[i] <= '0;
		end else begin
			if (cdb_wr) begin
				regs_q[i_cdb.pd] <= i_cdb.data;
				rdy_q[i_cdb.pd]  <= 1'b1;
			end
			if (i_alloc_valid && i_alloc_pd != '0)
				rdy_q[i_alloc_pd] <= 1'b0; // New producer in flight
		end
	end

endmodule

//--- verilog/reservation_station.sv
`timescale 1ns/100ps

module reservation_station (
	input  logic                         clk,
	input  logic                         i_arst_n,
	input  logic                         i_disp_valid,
	input  issue_pkg::rs_entry_t         i_entry,
	output logic                         o_disp_ready,
	input  issue_pkg::cdb_t              i_cdb,
	output logic [issue_pkg::NUM_FU-1:0] o_issue_valid,
	output issue_pkg::issue_t            o_issue [issue_pkg::NUM_FU],
	input  logic [issue_pkg::NUM_FU-1:0] i_issue_ready
);

	issue_pkg::rs_entry_t           rs_q [issue_pkg::RS_DEPTH];
	logic [issue_pkg::RS_IDX_W-1:0] sel_idx [issue_pkg::NUM_FU];
	logic [issue_pkg::NUM_FU-1:0]   issue_fire;
	logic [issue_pkg::RS_IDX_W-1:0] free_idx;
	logic                           free_found;
	logic [issue_pkg::RS_IDX_W-1:0] alloc_idx;
	logic                           alloc;

	// Lowest-index ready slot per unit
	always_comb begin
		for (int u = 0; u < issue_pkg::NUM_FU; u++) begin
			o_issue_valid[u] = 1'b0;
			sel_idx[u]       = '0;
			for (int i = 0; i < issue_pkg::RS_DEPTH; i++) begin
				if (!o_issue_valid[u] && rs_q[i].in_use && rs_q[i].src1_rdy &&
				    rs_q[i].src2_rdy && rs_q[i].fu == issue_pkg::FU_W'(u)) begin
					o_issue_valid[u] = 1'b1;
					sel_idx[u]       = issue_pkg::RS_IDX_W'(i);
				end
			end
			o_issue[u].op  = rs_q[sel_idx[u]].op;
			o_issue[u].opa = rs_q[sel_idx[u]].src1_val;
			o_issue[u].opb = rs_q[sel_idx[u]].src2_val;
			o_issue[u].pd  = rs_q[sel_idx[u]].pd;
			o_issue[u].rob = rs_q[sel_idx[u]].rob;
		end
	end

	assign issue_fire = o_issue_valid & i_issue_ready;

	always_comb begin
		free_found = 1'b0;
		free_idx   = '0;
		for (int i = 0; i < issue_pkg::RS_DEPTH; i++) begin
			if (!free_found && !rs_q[i].in_use) begin
				free_found = 1'b1;
				free_idx   = issue_pkg::RS_IDX_W'(i);
			end
		end
	end

	// A full station can still take the slot that issues this cycle
	assign o_disp_ready = free_found | (|issue_fire);
	assign alloc        = i_disp_valid & o_disp_ready;

	always_comb begin
		if (free_found)
			alloc_idx = free_idx;
		else if (issue_fire[0])
			alloc_idx = sel_idx[0];
		else
			alloc_idx = sel_idx[1];
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int i = 0; i < issue_pkg::RS_DEPTH; i++)
				rs_q[i] <= '0;
		end else begin
			// Wakeup from the broadcast
			if (i_cdb.valid) begin
				for (int i = 0; i < issue_pkg::RS_DEPTH; i++) begin
					if (rs_q[i].in_use && !rs_q[i].src1_rdy && rs_q[i].src1_tag == i_cdb.pd) begin
						rs_q[i].src1_val <= i_cdb.data;
						rs_q[i].src1_rdy <= 1'b1;
					end
					if (rs_q[i].in_use && !rs_q[i].src2_rdy && rs_q[i].src2_tag == i_cdb.pd) begin
						rs_q[i].src2_val <= i_cdb.data;
						rs_q[i].src2_rdy <= 1'b1;
					end
				end
			end

			for (int u = 0; u < issue_pkg::NUM_FU; u++) begin
				if (issue_fire[u])
					rs_q[sel_idx[u]].in_use <= 1'b0;
			end

			if (alloc)
				rs_q[alloc_idx] <= i_entry; // Last, so it wins over a same-slot free
		end
	end

endmodule

//--- verilog/alu_unit.sv
`timescale 1ns/100ps

module alu_unit #(
	parameter logic [issue_pkg::FU_W-1:0] FU_ID = '0
) (
	input  logic              clk,
	input  logic              i_arst_n,
	input  logic              i_issue_valid,
	input  issue_pkg::issue_t i_issue,
	output logic              o_issue_ready,
	output logic              o_req,
	output issue_pkg::cdb_t   o_result,
	input  logic              i_grant
);

	logic                       valid_q;
	issue_pkg::cdb_t            res_q;
	logic [issue_pkg::XLEN-1:0] alu_out;

	always_comb begin
		case (i_issue.op)
			issue_pkg::ALU_ADD: alu_out = i_issue.opa + i_issue.opb;
			issue_pkg::ALU_SUB: alu_out = i_issue.opa - i_issue.opb;
			issue_pkg::ALU_XOR: alu_out = i_issue.opa ^ i_issue.opb;
			issue_pkg::ALU_SRA: alu_out = $signed(i_issue.opa) >>> i_issue.opb[4:0];
			issue_pkg::ALU_AND: alu_out = i_issue.opa & i_issue.opb;
			default:            alu_out = i_issue.opa + i_issue.opb;
		endcase
	end

	// Free slot, or the held result leaves this cycle
	assign o_issue_ready = !valid_q || i_grant;
	assign o_req         = valid_q;

	always_comb begin
		o_result       = res_q;
		o_result.valid = valid_q;
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			valid_q <= 1'b0;
		else if (i_issue_valid && o_issue_ready)
			valid_q <= 1'b1;
		else if (i_grant)
			valid_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (i_issue_valid && o_issue_ready) begin
			res_q.valid <= 1'b1;
			res_q.pd    <= i_issue.pd;
			res_q.data  <= alu_out;
			res_q.rob   <= i_issue.rob;
			res_q.fu    <= FU_ID;
		end
	end

endmodule

//--- verilog/cdb_arbiter.sv
`timescale 1ns/100ps

module cdb_arbiter (
	input  logic                         clk,
	input  logic                         i_arst_n,
	input  logic [issue_pkg::NUM_FU-1:0] i_req,
	input  issue_pkg::cdb_t              i_result [issue_pkg::NUM_FU],
	output logic [issue_pkg::NUM_FU-1:0] o_grant,
	output issue_pkg::cdb_t              o_cdb
);

	logic last_q; // Unit that won most recently

	// Unit 1 wins a tie only when unit 0 won last
	assign o_grant[1] = i_req[1] && (!i_req[0] || !last_q);
	assign o_grant[0] = i_req[0] && !o_grant[1];

	always_comb begin
		o_cdb       = o_grant[1] ? i_result[1] : i_result[0];
		o_cdb.valid = |o_grant;
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			last_q <= 1'b1; // Unit 0 first after reset
		else if (|o_grant)
			last_q <= o_grant[1];
	end

endmodule

//--- verilog/issue_core.sv
`timescale 1ns/100ps

module issue_core (
	input  logic                 clk,
	input  logic                 i_arst_n,
	input  logic                 i_disp_valid,
	input  issue_pkg::disp_req_t i_disp,
	output logic                 o_disp_ready,
	output issue_pkg::cdb_t      o_cdb
);

	logic                               disp_accept;
	logic [issue_pkg::PREG_W-1:0]       ps1;
	logic [issue_pkg::PREG_W-1:0]       ps2;
	issue_pkg::src_t                    src1;
	issue_pkg::src_t                    src2;
	issue_pkg::rs_entry_t               entry;
	logic [issue_pkg::NUM_FU-1:0]       issue_valid;
	issue_pkg::issue_t                  issue [issue_pkg::NUM_FU];
	logic [issue_pkg::NUM_FU-1:0]       issue_ready;
	logic [issue_pkg::NUM_FU-1:0]       fu_req;
	issue_pkg::cdb_t                    fu_result [issue_pkg::NUM_FU];
	logic [issue_pkg::NUM_FU-1:0]       fu_grant;
	issue_pkg::cdb_t                    cdb;

	assign disp_accept = i_disp_valid & o_disp_ready;
	assign o_cdb = cdb;

	dispatch_decode u_decode (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_accept (disp_accept),
		.i_disp   (i_disp),
		.o_ps1    (ps1),
		.o_ps2    (ps2),
		.i_src1   (src1),
		.i_src2   (src2),
		.o_entry  (entry)
	);

	phys_regfile u_prf (
		.clk           (clk),
		.i_arst_n      (i_arst_n),
		.i_ps1         (ps1),
		.i_ps2         (ps2),
		.o_src1        (src1),
		.o_src2        (src2),
		.i_alloc_valid (disp_accept),
		.i_alloc_pd    (i_disp.pd),
		.i_cdb         (cdb)
	);

	reservation_station u_rs (
		.clk           (clk),
		.i_arst_n      (i_arst_n),
		.i_disp_valid  (i_disp_valid),
		.i_entry       (entry),
		.o_disp_ready  (o_disp_ready),
		.i_cdb         (cdb),
		.o_issue_valid (issue_valid),
		.o_issue       (issue),
		.i_issue_ready (issue_ready)
	);

	alu_unit #(.FU_ID(1'b0)) u_alu0 (
		.clk           (clk),
		.i_arst_n      (i_arst_n),
		.i_issue_valid (issue_valid[0]),
		.i_issue       (issue[0]),
		.o_issue_ready (issue_ready[0]),
		.o_req         (fu_req[0]),
		.o_result      (fu_result[0]),
		.i_grant       (fu_grant[0])
	);

	alu_unit #(.FU_ID(1'b1)) u_alu1 (
		.clk           (clk),
		.i_arst_n      (i_arst_n),
		.i_issue_valid (issue_valid[1]),
		.i_issue       (issue[1]),
		.o_issue_ready (issue_ready[1]),
		.o_req         (fu_req[1]),
		.o_result      (fu_result[1]),
		.i_grant       (fu_grant[1])
	);

	cdb_arbiter u_arb (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_req    (fu_req),
		.i_result (fu_result),
		.o_grant  (fu_grant),
		.o_cdb    (cdb)
	);

endmodule

//--- tb/issue_model.svh
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// Instruction kinds used by the stimulus
localparam int K_ADD  = 0;
localparam int K_SUB  = 1;
localparam int K_XOR  = 2;
localparam int K_SRA  = 3;
localparam int K_ADDI = 4;
localparam int K_ANDI = 5;

logic [31:0]     shadow [issue_pkg::NUM_PREGS]; // Program-order register values
issue_pkg::cdb_t exp_tab [issue_pkg::RS_DEPTH];   // Indexed by ROB tag
bit              seen [issue_pkg::RS_DEPTH];
int              cur_n;
int              results;
int              bcasts; // Every broadcast in the batch, duplicates and strays too
int              disp_total; // Dispatches since reset, sets the unit
bit              batch_active;

task automatic reset_model();
	for (int r = 0; r < issue_pkg::NUM_PREGS; r++)
		shadow[r] = '0;
	cur_n        = 0;
	results      = 0;
	bcasts       = 0;
	disp_total   = 0;
	batch_active = 1'b0;
endtask

function automatic logic [31:0] predict_result(input int kind, input logic [31:0] a,
	input logic [31:0] b, input logic [11:0] imm);
	logic signed [31:0] sa;
	sa = a;
	case (kind)
		K_ADD:   return a + b;
		K_SUB:   return a - b;
		K_XOR:   return a ^ b;
		K_SRA:   return sa >>> b[4:0]; // Shift amount from the low five bits only
		K_ADDI:  return a + {20'h0, imm};
		default: return a & {20'h0, imm};
	endcase
endfunction

// Called in dispatch order
task automatic record_expected(input int idx, input int kind, input int s1, input int s2,
	input int pd, input logic [11:0] imm);
	logic [31:0] val;
	val = predict_result(kind, shadow[s1], shadow[s2], imm);
	exp_tab[idx].pd    = issue_pkg::PREG_W'(pd);
	exp_tab[idx].data  = val;
	exp_tab[idx].fu    = issue_pkg::FU_W'(disp_total % 2);
	disp_total++;
	if (pd != 0)
		shadow[pd] = val; // x0 stays zero for later readers
endtask

task automatic start_batch(input int n);
	for (int i = 0; i < issue_pkg::RS_DEPTH; i++)
		seen[i] = 1'b0;
	cur_n        = n;
	results      = 0;
	bcasts       = 0;
	batch_active = 1'b1;
endtask

task automatic check_cdb(input issue_pkg::cdb_t got);
	issue_pkg::cdb_t exp;
	bcasts++;
	if (!batch_active || got.rob >= cur_n) begin
		$display("ERR %0t: broadcast with ROB tag %0d outside the batch", $time, got.rob);
		err_cnt++;
	end else if (seen[got.rob]) begin
		$display("ERR %0t: ROB tag %0d broadcast twice", $time, got.rob);
		err_cnt++;
	end else begin
		exp            = exp_tab[got.rob];
		seen[got.rob]  = 1'b1;
		results++;
		if (got.data !== exp.data || got.pd !== exp.pd || got.fu !== exp.fu) begin
			$display("ERR %0t: ROB %0d got pd %0d data %h fu %0d, expected pd %0d data %h fu %0d",
				$time, got.rob, got.pd, got.data, got.fu, exp.pd, exp.data, exp.fu);
			err_cnt++;
		end
	end
endtask

task automatic check_count(input int got, input int exp, input string what);
	if (got != exp) begin
		$display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
		err_cnt++;
	end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
	if (got !== exp) begin
		$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
		err_cnt++;
	end
endtask

`endif

//--- tb/tb_issue_core.sv
`timescale 1ns/100ps

module tb_issue_core;

	localparam int NUM_BATCHES    = 40;
	localparam int DISP_TIMEOUT   = 200;
	localparam int RESULT_TIMEOUT = 400;

	logic                 clk;
	logic                 i_arst_n;
	logic                 i_disp_valid;
	issue_pkg::disp_req_t i_disp;
	logic                 o_disp_ready;
	issue_pkg::cdb_t      o_cdb;

	int  seed;
	int  err_cnt;
	int  timeout_cnt;
	bit  aborted;

	issue_pkg::disp_req_t batch_q [issue_pkg::RS_DEPTH];
	int                   batch_pd [issue_pkg::RS_DEPTH];
	bit                   in_batch [issue_pkg::NUM_PREGS];
	bit                   is_live [issue_pkg::NUM_PREGS];
	int                   live_regs [$]; // Registers written by earlier batches

	`include "issue_model.svh"

	issue_core UUT (
		.clk          (clk),
		.i_arst_n     (i_arst_n),
		.i_disp_valid (i_disp_valid),
		.i_disp       (i_disp),
		.o_disp_ready (o_disp_ready),
		.o_cdb        (o_cdb)
	);

	always #50 clk = ~clk;

	// Broadcasts are steady between rising edges
	always @(negedge clk) begin
		if (i_arst_n && o_cdb.valid)
			check_cdb(o_cdb);
	end

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [31:0] encode_instr(input int kind, input int s1, input int s2,
		input int pd, input logic [11:0] imm);
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		rs1 = s1[4:0];
		rs2 = s2[4:0];
		rd  = pd[4:0];
		case (kind)
			K_ADD:   return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
			K_SUB:   return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
			K_XOR:   return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
			K_SRA:   return {7'b0100000, rs2, rs1, 3'b101, rd, 7'b0110011};
			K_ADDI:  return {imm, rs1, 3'b000, rd, 7'b0010011};
			default: return {imm, rs1, 3'b111, rd, 7'b0010011};
		endcase
	endfunction

	// Earlier result in this batch, or a register this batch leaves alone
	function automatic int pick_source(input int i);
		int r;
		if (i > 0 && rand_below(2) == 0)
			return batch_pd[rand_below(i)];
		r = live_regs[rand_below(live_regs.size())];
		if (in_batch[r])
			return 0;
		return r;
	endfunction

	task automatic build_batch(input int n);
		int          kind;
		int          s1;
		int          s2;
		logic [11:0] imm;
		for (int r = 0; r < issue_pkg::NUM_PREGS; r++)
			in_batch[r] = 1'b0;
		for (int i = 0; i < n; i++) begin
			if (rand_below(8) == 0) begin
				batch_pd[i] = 0;
			end else begin
				batch_pd[i] = 1 + rand_below(63);
				while (in_batch[batch_pd[i]])
					batch_pd[i] = 1 + rand_below(63);
				in_batch[batch_pd[i]] = 1'b1;
			end
		end
		for (int i = 0; i < n; i++) begin
			kind = rand_below(6);
			s1   = pick_source(i);
			s2   = (kind >= K_ADDI) ? 0 : pick_source(i);
			imm  = 12'(rand_below(4096));
			batch_q[i].instr = encode_instr(kind, s1, s2, batch_pd[i], imm);
			batch_q[i].ps1   = issue_pkg::PREG_W'(s1);
			batch_q[i].ps2   = issue_pkg::PREG_W'(s2);
			batch_q[i].pd    = issue_pkg::PREG_W'(batch_pd[i]);
			batch_q[i].rob   = issue_pkg::ROB_W'(i);
			record_expected(i, kind, s1, s2, batch_pd[i], imm);
		end
		for (int i = 0; i < n; i++) begin
			if (batch_pd[i] != 0 && !is_live[batch_pd[i]]) begin
				is_live[batch_pd[i]] = 1'b1;
				live_regs.push_back(batch_pd[i]);
			end
		end
	endtask

	task automatic dispatch_one(input issue_pkg::disp_req_t req, output bit ok);
		int waited;
		waited = 0;
		ok     = 1'b0;
		@(negedge clk);
		i_disp_valid = 1'b1;
		i_disp       = req;
		while (!o_disp_ready && waited < DISP_TIMEOUT) begin
			waited++;
			@(negedge clk);
		end
		if (o_disp_ready) begin
			@(posedge clk); // Accepted on this edge
			ok = 1'b1;
		end else begin
			$display("Timeout: ROB tag %0d was never accepted by the station", req.rob);
			timeout_cnt++;
		end
	endtask

	task automatic wait_results(input int n, output bit ok);
		int waited;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (results < n && waited < RESULT_TIMEOUT);
		ok = (results >= n);
		if (!ok) begin
			$display("Timeout: only %0d of %0d results came back on the CDB", results, n);
			timeout_cnt++;
		end
	endtask

	initial begin
		int n;
		bit ok;
		seed         = 62272;
		clk          = 1'b0;
		i_arst_n     = 1'b0;
		i_disp_valid = 1'b0;
		i_disp       = '0;
		err_cnt      = 0;
		timeout_cnt  = 0;
		aborted      = 1'b0;
		reset_model();
		for (int r = 0; r < issue_pkg::NUM_PREGS; r++)
			is_live[r] = 1'b0;
		is_live[0] = 1'b1;
		live_regs.push_back(0);

		repeat (16) @(posedge clk);
		@(negedge clk);
		i_arst_n = 1'b1;
		@(negedge clk);
		check_flag(o_cdb.valid, 1'b0, "o_cdb.valid after reset");
		check_flag(o_disp_ready, 1'b1, "o_disp_ready after reset");

		for (int b = 0; b < NUM_BATCHES && !aborted; b++) begin
			n = (b % 4 == 3) ? 16 : 1 + rand_below(16); // Every fourth batch is a full 16
			build_batch(n);
			start_batch(n);
			for (int i = 0; i < n && !aborted; i++) begin
				dispatch_one(batch_q[i], ok);
				if (!ok)
					aborted = 1'b1;
			end
			@(negedge clk);
			i_disp_valid = 1'b0;
			if (!aborted) begin
				wait_results(n, ok);
				if (!ok)
					aborted = 1'b1;
			end
			repeat (4) @(posedge clk); // Quiet window to catch stray broadcasts
			check_count(bcasts, n, "broadcast count");
			batch_active = 1'b0;
		end

		$display("Errors: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
		if (err_cnt == 0 && timeout_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+tb
verilog/issue_pkg.sv
verilog/dispatch_decode.sv
verilog/phys_regfile.sv
verilog/reservation_station.sv
verilog/alu_unit.sv
verilog/cdb_arbiter.sv
verilog/issue_core.sv
tb/tb_issue_core.sv
